/* hdl/lsu_pkg.sv */
// Load/store unit shared types
`default_nettype none

package lsu_pkg;

    // Data and address width.
    localparam int XLEN  = 32;
    // Byte lanes on the data bus.
    localparam int LANES = 4;

    typedef enum logic [1:0] {
        OP_LOAD,
        OP_STORE,
        OP_AMO
    } mem_op_e;

    // Same encoding as instruction bits 13:12.
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } access_size_e;

    // Same encoding as instruction bits 31:29.
    typedef enum logic [2:0] {
        AMO_ADD  = 3'b000,
        AMO_XOR  = 3'b001,
        AMO_OR   = 3'b010,
        AMO_AND  = 3'b011,
        AMO_MIN  = 3'b100,
        AMO_MAX  = 3'b101,
        AMO_MINU = 3'b110,
        AMO_MAXU = 3'b111
    } amo_fn_e;

    typedef enum logic [1:0] {
        FAULT_NONE,
        FAULT_LOAD_ALIGN,
        FAULT_STORE_ALIGN
    } fault_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_AMO_MODIFY,
        ST_AMO_WRITE
    } ctrl_state_e;

    typedef struct packed {
        mem_op_e          op;
        access_size_e     size;
        logic             is_signed;
        amo_fn_e          amo_fn;
        logic [XLEN-1:0]  addr;
        logic [XLEN-1:0]  wdata;
    } lsu_req_t;

    typedef struct packed {
        logic [XLEN-1:0]  rdata;
        fault_e           fault;
    } lsu_rsp_t;

    // Word addressed bus request.
    typedef struct packed {
        logic             re;
        logic [LANES-1:0] we;
        logic [XLEN-3:0]  addr;
        logic [XLEN-1:0]  wdata;
    } mem_req_t;

    typedef struct packed {
        logic             ready;
        logic [XLEN-1:0]  rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

/* hdl/store_lanes.sv */
// Store lane steering
`default_nettype none
`timescale 1ns/1ps

module store_lanes (
    input  wire  lsu_pkg::lsu_req_t            req,
    input  wire  [lsu_pkg::XLEN-1:0]           write_data,
    output logic                               misaligned,
    output logic [lsu_pkg::LANES-1:0]          byte_en,
    output logic [lsu_pkg::XLEN-1:0]           lane_wdata
);
    import lsu_pkg::*;

    access_size_e eff_size;

    // AMOs always move a full word.
    assign eff_size = (req.op == OP_AMO) ? SIZE_WORD : req.size;

    always_comb begin
        misaligned = 1'b0;
        byte_en    = '0;
        lane_wdata = write_data;
        case (eff_size)
            SIZE_BYTE: begin
                byte_en    = LANES'(1) << req.addr[1:0];
                lane_wdata = {LANES{write_data[7:0]}};
            end
            SIZE_HALF: begin
                misaligned = req.addr[0];
                if (req.addr[1]) begin
                    byte_en = 4'b1100;
                end else begin
                    byte_en = 4'b0011;
                end
                lane_wdata = {2{write_data[15:0]}};
            end
            SIZE_WORD: begin
                misaligned = req.addr[1:0] != 2'b00;
                byte_en    = '1;
            end
            default: begin
                // Unsupported size faults instead of hanging the bus.
                misaligned = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/load_extract.sv */
// Load data extraction
`default_nettype none
`timescale 1ns/1ps

module load_extract (
    input  wire  lsu_pkg::lsu_req_t            req,
    input  wire  [lsu_pkg::XLEN-1:0]           word,
    output logic [lsu_pkg::XLEN-1:0]           load_data
);
    import lsu_pkg::*;

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // Pick the addressed lane.
    always_comb begin
        case (req.addr[1:0])
            2'b00:   sel_byte = word[7:0];
            2'b01:   sel_byte = word[15:8];
            2'b10:   sel_byte = word[23:16];
            default: sel_byte = word[31:24];
        endcase
        if (req.addr[1]) begin
            sel_half = word[31:16];
        end else begin
            sel_half = word[15:0];
        end
    end

    // Sign or zero extend.
    always_comb begin
        case (req.size)
            SIZE_BYTE: begin
                load_data = {{(XLEN-8){req.is_signed & sel_byte[7]}}, sel_byte};
            end
            SIZE_HALF: begin
                load_data = {{(XLEN-16){req.is_signed & sel_half[15]}}, sel_half};
            end
            default: begin
                load_data = word;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/amo_alu.sv */
// AMO write value ALU
`default_nettype none
`timescale 1ns/1ps

module amo_alu (
    input  wire  lsu_pkg::amo_fn_e             fn,
    input  wire  [lsu_pkg::XLEN-1:0]           old_val,
    input  wire  [lsu_pkg::XLEN-1:0]           operand,
    output logic [lsu_pkg::XLEN-1:0]           result
);
    import lsu_pkg::*;

    logic            cmp_signed;
    logic [XLEN-1:0] lhs;
    logic [XLEN-1:0] rhs;
    logic [XLEN:0]   diff;
    logic            old_ge;

    // Shared compare for min and max.
    always_comb begin
        cmp_signed = (fn == AMO_MIN) || (fn == AMO_MAX);
        lhs        = old_val;
        rhs        = operand;
        if (cmp_signed) begin
            // Flipping the sign bit turns a signed compare into an unsigned one.
            lhs[XLEN-1] = ~lhs[XLEN-1];
            rhs[XLEN-1] = ~rhs[XLEN-1];
        end
        diff   = {1'b0, lhs} + {1'b0, ~rhs} + 1'b1;
        // Carry out set means old value >= operand.
        old_ge = diff[XLEN];
    end

    always_comb begin
        case (fn)
            AMO_ADD: result = old_val + operand;
            AMO_XOR: result = old_val ^ operand;
            AMO_OR:  result = old_val | operand;
            AMO_AND: result = old_val & operand;
            AMO_MIN, AMO_MINU: begin
                result = old_ge ? operand : old_val;
            end
            AMO_MAX, AMO_MAXU: begin
                result = old_ge ? old_val : operand;
            end
            default: result = old_val;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/lsu_ctrl.sv */
// Load/store unit controller
`default_nettype none
`timescale 1ns/1ps

module lsu_ctrl (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                req_valid,
    input  wire  lsu_pkg::lsu_req_t            req,
    input  wire                                misaligned,
    input  wire  [lsu_pkg::LANES-1:0]          byte_en,
    input  wire  [lsu_pkg::XLEN-1:0]           lane_wdata,
    input  wire  [lsu_pkg::XLEN-1:0]           load_data,
    input  wire  [lsu_pkg::XLEN-1:0]           amo_result,
    input  wire  lsu_pkg::mem_rsp_t            mem_rsp,
    output lsu_pkg::lsu_req_t                  cur_req,
    output lsu_pkg::mem_req_t                  mem_req,
    output logic                               done,
    output lsu_pkg::lsu_rsp_t                  rsp
);
    import lsu_pkg::*;

    ctrl_state_e     state;
    logic            done_q;
    logic            fault_done;
    logic [XLEN-1:0] rdata_q;
    logic [XLEN-1:0] amo_wdata;

    // A misaligned access ends in its first cycle without touching the bus.
    assign fault_done = (state == ST_ACCESS) && misaligned;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req_valid) begin
                        state <= ST_ACCESS;
                    end
                end
                ST_ACCESS: begin
                    if (misaligned) begin
                        state <= ST_IDLE;
                    end else if (mem_rsp.ready) begin
                        if (cur_req.op == OP_AMO) begin
                            state <= ST_AMO_MODIFY;
                        end else begin
                            state  <= ST_IDLE;
                            done_q <= 1'b1;
                        end
                    end
                end
                ST_AMO_MODIFY: begin
                    state <= ST_AMO_WRITE;
                end
                ST_AMO_WRITE: begin
                    if (mem_rsp.ready) begin
                        state  <= ST_IDLE;
                        done_q <= 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Request, old value and AMO write value.
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req_valid) begin
            cur_req <= req;
            rdata_q <= '0;
        end
        if (state == ST_ACCESS && !misaligned && mem_rsp.ready) begin
            if (cur_req.op == OP_LOAD) begin
                rdata_q <= load_data;
            end else if (cur_req.op == OP_AMO) begin
                rdata_q <= mem_rsp.rdata;
            end
        end
        if (state == ST_AMO_MODIFY) begin
            amo_wdata <= amo_result;
        end
    end

    always_comb begin
        mem_req = '0;
        if (state == ST_ACCESS && !misaligned) begin
            mem_req.re    = (cur_req.op == OP_LOAD) || (cur_req.op == OP_AMO);
            mem_req.we    = (cur_req.op == OP_STORE) ? byte_en : '0;
            mem_req.addr  = cur_req.addr[XLEN-1:2];
            mem_req.wdata = lane_wdata;
        end else if (state == ST_AMO_WRITE) begin
            // Second half of the read-modify-write.
            mem_req.we    = byte_en;
            mem_req.addr  = cur_req.addr[XLEN-1:2];
            mem_req.wdata = amo_wdata;
        end
    end

    assign done = done_q || fault_done;

    always_comb begin
        rsp.rdata = rdata_q;
        rsp.fault = FAULT_NONE;
        if (fault_done) begin
            rsp.fault = (cur_req.op == OP_LOAD) ? FAULT_LOAD_ALIGN : FAULT_STORE_ALIGN;
        end
    end

endmodule

`default_nettype wire

/* hdl/lsu_top.sv */
// Load/store unit top level
`default_nettype none
`timescale 1ns/1ps

module lsu_top (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                req_valid,
    input  wire  lsu_pkg::lsu_req_t            req,
    output logic                               done,
    output lsu_pkg::lsu_rsp_t                  rsp,
    output lsu_pkg::mem_req_t                  mem_req,
    input  wire  lsu_pkg::mem_rsp_t            mem_rsp
);
    import lsu_pkg::*;

    lsu_req_t         cur_req;
    logic             misaligned;
    logic [LANES-1:0] byte_en;
    logic [XLEN-1:0]  lane_wdata;
    logic [XLEN-1:0]  load_data;
    logic [XLEN-1:0]  amo_result;

    lsu_ctrl lsu_ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .misaligned (misaligned),
        .byte_en    (byte_en),
        .lane_wdata (lane_wdata),
        .load_data  (load_data),
        .amo_result (amo_result),
        .mem_rsp    (mem_rsp),
        .cur_req    (cur_req),
        .mem_req    (mem_req),
        .done       (done),
        .rsp        (rsp)
    );

    store_lanes store_lanes_i (
        .req        (cur_req),
        .write_data (cur_req.wdata),
        .misaligned (misaligned),
        .byte_en    (byte_en),
        .lane_wdata (lane_wdata)
    );

    // Bus read data is only sampled in the ready cycle.
    load_extract load_extract_i (
        .req       (cur_req),
        .word      (mem_rsp.rdata),
        .load_data (load_data)
    );

    // Old value comes from the registered response data.
    amo_alu amo_alu_i (
        .fn      (cur_req.amo_fn),
        .old_val (rsp.rdata),
        .operand (cur_req.wdata),
        .result  (amo_result)
    );

endmodule

`default_nettype wire

/* tests/lsu_sva.sv */
// Load/store unit bus checks
`default_nettype none
`timescale 1ns/1ps

module lsu_sva (
    input wire                        clk,
    input wire                        rst,
    input wire                        done,
    input wire lsu_pkg::ctrl_state_e  state,
    input wire lsu_pkg::mem_req_t     mem_req,
    input wire lsu_pkg::mem_rsp_t     mem_rsp
);
    import lsu_pkg::*;

    logic bus_active;

    assign bus_active = mem_req.re || (mem_req.we != '0);

    // Read and write are exclusive.
    assert property (@(posedge clk) disable iff (rst) !(mem_req.re && mem_req.we != '0))
        else $error("bus read and write active together");

    // Done is a one cycle strobe.
    assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done held for more than one cycle");

    // Request held until the memory takes it.
    assert property (@(posedge clk) disable iff (rst)
        bus_active && !mem_rsp.ready |=> $stable(mem_req))
        else $error("bus request changed while ready was low");

    assert property (@(posedge clk) disable iff (rst) state == ST_IDLE |-> !bus_active)
        else $error("bus access while the controller is idle");

endmodule

`default_nettype wire

/* tests/lsu_tb.sv */
// Load/store unit testbench
`default_nettype none
`timescale 1ns/1ps

module lsu_tb;
    import lsu_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int N_SUB        = 40;
    localparam int N_MIS        = 12;
    localparam int N_AMO_OPS    = 64;
    localparam int N_RAND       = 60;
    // Worst case AMO: strobe, two 4 cycle bus phases, modify, done, gap.
    localparam int OP_CYCLES    = 12;
    localparam int N_OPS        = 2 + 2 * N_SUB + N_MIS + N_AMO_OPS + N_RAND;
    localparam int MAX_CYCLES   = RESET_CYCLES + N_OPS * OP_CYCLES;

    logic        clk = 1'b0;
    logic        rst;
    logic        req_valid;
    lsu_req_t    req;
    logic        done;
    lsu_rsp_t    rsp;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;

    logic [15:0] lfsr_q = 16'd6;
    logic [31:0] bus_mem [16];
    logic [31:0] ref_mem [16];
    int          lat_q [$];
    int          wait_cnt;
    bit          in_access = 1'b0;
    int          bus_cycles = 0;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int          ops_done = 0;

    always #20 clk = ~clk;

    lsu_top lsu_top_i (.*);

    bind lsu_ctrl lsu_sva lsu_sva_i (.*);

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v     = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic access_size_e random_size();
        return access_size_e'(2'(rand_bits(2) % 3));
    endfunction

    // Random aligned request inside the 16 word memory.
    function automatic lsu_req_t random_req(mem_op_e op, access_size_e size);
        lsu_req_t r;
        r           = '0;
        r.op        = op;
        r.size      = size;
        r.is_signed = rand_bits(1);
        r.amo_fn    = amo_fn_e'(3'(rand_bits(3)));
        r.addr      = rand_bits(6);
        r.wdata     = rand_bits(32);
        if (op == OP_AMO || size == SIZE_WORD) begin
            r.addr[1:0] = 2'b00;
        end else if (size == SIZE_HALF) begin
            r.addr[0] = 1'b0;
        end
        return r;
    endfunction

    function automatic bit misaligned_access(lsu_req_t r);
        if (r.op == OP_AMO || r.size == SIZE_WORD) begin
            return r.addr[1:0] != 2'b00;
        end
        return (r.size == SIZE_HALF) && r.addr[0];
    endfunction

    function automatic logic [31:0] load_value(lsu_req_t r, logic [31:0] w);
        logic [31:0] sh;
        sh = w >> (8 * r.addr[1:0]);
        case (r.size)
            SIZE_BYTE: return r.is_signed ? {{24{sh[7]}}, sh[7:0]} : {24'b0, sh[7:0]};
            SIZE_HALF: return r.is_signed ? {{16{sh[15]}}, sh[15:0]} : {16'b0, sh[15:0]};
            default:   return w;
        endcase
    endfunction

    function automatic logic [31:0] amo_value(amo_fn_e fn, logic [31:0] m, logic [31:0] v);
        case (fn)
            AMO_ADD:  return m + v;
            AMO_XOR:  return m ^ v;
            AMO_OR:   return m | v;
            AMO_AND:  return m & v;
            AMO_MIN:  return ($signed(m) < $signed(v)) ? m : v;
            AMO_MAX:  return ($signed(m) > $signed(v)) ? m : v;
            AMO_MINU: return (m < v) ? m : v;
            default:  return (m > v) ? m : v;
        endcase
    endfunction

    // Signed and unsigned extremes for min and max.
    function automatic logic [31:0] edge_value(int k);
        case (k)
            0:       return 32'h8000_0000;
            1:       return 32'h7fff_ffff;
            2:       return 32'hffff_ffff;
            default: return 32'h0000_0001;
        endcase
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Memory on the bus side, with a queued ready latency per access.
    always @(posedge clk) begin
        #1;
        mem_rsp = '0;
        if (mem_req.re || mem_req.we != '0) begin
            bus_cycles++;
            if (!in_access) begin
                in_access = 1'b1;
                wait_cnt  = (lat_q.size() > 0) ? lat_q.pop_front() : 0;
            end
            if (wait_cnt == 0) begin
                mem_rsp.ready = 1'b1;
                mem_rsp.rdata = bus_mem[mem_req.addr[3:0]];
                for (int b = 0; b < 4; b++) begin
                    if (mem_req.we[b]) begin
                        bus_mem[mem_req.addr[3:0]][b*8 +: 8] = mem_req.wdata[b*8 +: 8];
                    end
                end
                in_access = 1'b0;
            end else begin
                wait_cnt--;
            end
        end
    end

    // Issue one request and compare the response with the model.
    task automatic run_op(input lsu_req_t r);
        logic [3:0]  idx;
        logic [31:0] exp_rdata;
        fault_e      exp_fault;
        int          start_bus;
        int          waited;
        idx       = r.addr[5:2];
        exp_rdata = '0;
        exp_fault = FAULT_NONE;
        if (misaligned_access(r)) begin
            exp_fault = (r.op == OP_LOAD) ? FAULT_LOAD_ALIGN : FAULT_STORE_ALIGN;
        end else begin
            lat_q.push_back(rand_bits(2));
            case (r.op)
                OP_LOAD: exp_rdata = load_value(r, ref_mem[idx]);
                OP_STORE: begin
                    case (r.size)
                        SIZE_BYTE: ref_mem[idx][8*r.addr[1:0] +: 8]  = r.wdata[7:0];
                        SIZE_HALF: ref_mem[idx][8*r.addr[1:0] +: 16] = r.wdata[15:0];
                        default:   ref_mem[idx] = r.wdata;
                    endcase
                end
                default: begin
                    lat_q.push_back(rand_bits(2));
                    exp_rdata    = ref_mem[idx];
                    ref_mem[idx] = amo_value(r.amo_fn, ref_mem[idx], r.wdata);
                end
            endcase
        end
        start_bus = bus_cycles;
        req       = r;
        req_valid = 1'b1;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        waited    = 0;
        while (!done && waited < OP_CYCLES) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!done) begin
            $display("No done within %0d cycles for request at %h", OP_CYCLES, r.addr);
            errors++;
        end else begin
            ops_done++;
            check_value("rsp.fault", rsp.fault, exp_fault);
            if (exp_fault == FAULT_NONE) begin
                check_value("rsp.rdata", rsp.rdata, exp_rdata);
            end else begin
                check_value("fault done delay", waited, 0);
            end
            check_value("bus_mem", bus_mem[idx], ref_mem[idx]);
            @(posedge clk);
            #1;
            check_value("done", done, 0);
            // The memory has counted the fault cycle by now.
            if (exp_fault != FAULT_NONE) begin
                check_value("bus cycles on fault", bus_cycles - start_bus, 0);
            end
        end
    endtask

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped after %0d cycles without finishing", MAX_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int       e;
        int       n;
        lsu_req_t r;
        req_valid = 1'b0;
        req       = '0;
        mem_rsp   = '0;
        rst       = 1'b1;
        for (int i = 0; i < 16; i++) begin
            bus_mem[i] = 32'h5a00_0000 ^ (i * 32'h0103_0507);
            ref_mem[i] = bus_mem[i];
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        e = errors;
        check_value("done", done, 0);
        check_value("mem_req.re", mem_req.re, 0);
        check_value("mem_req.we", mem_req.we, 0);
        r       = random_req(OP_STORE, SIZE_WORD);
        r.wdata = 32'hc0de_1234;
        run_op(r);
        r.op = OP_LOAD;
        run_op(r);
        $display("test 1 reset and word store/load: %0d errors", errors - e);

        e = errors;
        for (int i = 0; i < N_SUB; i++) begin
            run_op(random_req(OP_STORE, access_size_e'(2'(rand_bits(1)))));
            run_op(random_req(OP_LOAD, random_size()));
        end
        $display("test 2 sub-word stores and loads: %0d errors", errors - e);

        e = errors;
        for (int i = 0; i < N_MIS; i++) begin
            r = random_req(mem_op_e'(2'(i % 3)), rand_bits(1) ? SIZE_HALF : SIZE_WORD);
            r.addr[0] = 1'b1;
            if (i % 4 == 0 && r.size == SIZE_WORD) begin
                r.addr[1:0] = 2'b10;
            end
            run_op(r);
        end
        $display("test 3 misaligned accesses: %0d errors", errors - e);

        e = errors;
        for (int f = 0; f < 8; f++) begin
            for (int k = 0; k < 4; k++) begin
                r       = random_req(OP_STORE, SIZE_WORD);
                r.wdata = edge_value(k);
                run_op(r);
                r.op     = OP_AMO;
                r.amo_fn = amo_fn_e'(f[2:0]);
                r.wdata  = edge_value(3 - k);
                run_op(r);
            end
        end
        $display("test 4 AMO functions: %0d errors", errors - e);

        e = errors;
        n = ops_done;
        for (int i = 0; i < N_RAND; i++) begin
            r = random_req(mem_op_e'(2'(rand_bits(2) % 3)), random_size());
            // Occasional odd address, misaligned unless a byte access.
            if (rand_bits(3) == 0) begin
                r.addr[0] = 1'b1;
            end
            run_op(r);
        end
        check_value("completed operations", ops_done - n, N_RAND);
        $display("test 5 random mix with ready delays: %0d errors", errors - e);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
hdl/lsu_pkg.sv
hdl/store_lanes.sv
hdl/load_extract.sv
hdl/amo_alu.sv
hdl/lsu_ctrl.sv
hdl/lsu_top.sv
tests/lsu_sva.sv
tests/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - hdl/lsu_pkg.sv
  - hdl/store_lanes.sv
  - hdl/load_extract.sv
  - hdl/amo_alu.sv
  - hdl/lsu_ctrl.sv
  - hdl/lsu_top.sv
  - target: test
    files:
      - tests/lsu_sva.sv
      - tests/lsu_tb.sv
